// File: Makefile
TOP = tb_mempool_mesh_cluster
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall --top-module mempool_mesh_cluster \
		hw/mesh_pkg.sv hw/dma_spill_register.sv hw/mesh_router.sv \
		hw/group_bank.sv hw/mempool_mesh_cluster.sv

clean:
	rm -rf obj_dir $(LOG)

// File: hw/dma_spill_register.sv
// ****************************************
// Two entry spill register for DMA requests
// ****************************************

module dma_spill_register
  import mesh_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  dma_req_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output dma_req_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  dma_req_t a_data_q, b_data_q;
  logic     a_full_q, b_full_q;
  logic     a_fill, a_drain;
  logic     b_fill, b_drain;

  // Slot A takes new requests, slot B catches A when the output stalls
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill | (a_full_q & ~a_drain);
      b_full_q <= b_fill | (b_full_q & ~b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B always holds the older request
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign valid_o = a_full_q | b_full_q;
  assign ready_o = ~a_full_q | ~b_full_q;

  // A stalled request must not change or vanish
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule : dma_spill_register

// File: hw/group_bank.sv
// ****************************************
// Group TCDM bank, runs DMA requests and
// keeps the group's DMA status
// ****************************************

module group_bank
  import mesh_pkg::*;
#(
  parameter int unsigned GroupX = 0,
  parameter int unsigned GroupY = 0
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  dma_req_t  req_i,
  input  logic      req_valid_i,
  output dma_meta_t meta_o
);

  data_t     mem_q [BankWords];
  data_t     old_word;
  data_t     new_word;
  dma_meta_t meta_q;

  assign old_word = mem_q[req_i.addr];

  always_comb begin
    unique case (req_i.op)
      DMA_WRITE: new_word = req_i.data;
      DMA_ADD:   new_word = old_word + req_i.data;
      DMA_CLEAR: new_word = '0;
      default:   new_word = old_word;
    endcase
  end

  // Bank comes out of reset cleared
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < BankWords; w++) begin
        mem_q[w] <= '0;
      end
      meta_q <= '0;
    end else if (req_valid_i) begin
      mem_q[req_i.addr] <= new_word;
      meta_q.count      <= meta_q.count + 8'd1;
      meta_q.last       <= new_word;
    end
  end

  assign meta_o = meta_q;

  // The mesh only delivers requests addressed to this group
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |-> req_i.dst_x == coord_t'(GroupX) && req_i.dst_y == coord_t'(GroupY));

endmodule : group_bank

// File: hw/mempool_mesh_cluster.sv
// ****************************************
// Mesh cluster top, builds the group mesh
// and registers the DMA status
// ****************************************

module mempool_mesh_cluster
  import mesh_pkg::*;
#(
  parameter  int unsigned NumX      = DefaultNumX,
  parameter  int unsigned NumY      = DefaultNumY,
  localparam int unsigned NumGroups = NumX * NumY
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  dma_req_t  [NumGroups-1:0]  dma_req_i,
  input  logic      [NumGroups-1:0]  dma_req_valid_i,
  output logic      [NumGroups-1:0]  dma_req_ready_o,
  output dma_meta_t [NumGroups-1:0]  dma_meta_o
);

  // Router side naming, in is what the router receives
  dma_req_t  [NumX-1:0][NumY-1:0][NumPorts-1:0] flit_in, flit_out;
  logic      [NumX-1:0][NumY-1:0][NumPorts-1:0] valid_in, valid_out;
  logic      [NumX-1:0][NumY-1:0][NumPorts-1:0] ready_in, ready_out;
  dma_meta_t [NumGroups-1:0]                    dma_meta, dma_meta_q;

  for (genvar x = 0; x < NumX; x++) begin : gen_groups_x
    for (genvar y = 0; y < NumY; y++) begin : gen_groups_y
      localparam int unsigned G = x * NumY + y;

      if (x > 0) begin : gen_west_link
        assign flit_in [x][y][WEST] = flit_out [x-1][y][EAST];
        assign valid_in[x][y][WEST] = valid_out[x-1][y][EAST];
        assign ready_in[x][y][WEST] = ready_out[x-1][y][EAST];
      end else begin : gen_west_edge
        assign flit_in [x][y][WEST] = '0;
        assign valid_in[x][y][WEST] = 1'b0;
        assign ready_in[x][y][WEST] = 1'b0;
      end

      if (x < NumX - 1) begin : gen_east_link
        assign flit_in [x][y][EAST] = flit_out [x+1][y][WEST];
        assign valid_in[x][y][EAST] = valid_out[x+1][y][WEST];
        assign ready_in[x][y][EAST] = ready_out[x+1][y][WEST];
      end else begin : gen_east_edge
        assign flit_in [x][y][EAST] = '0;
        assign valid_in[x][y][EAST] = 1'b0;
        assign ready_in[x][y][EAST] = 1'b0;
      end

      if (y > 0) begin : gen_south_link
        assign flit_in [x][y][SOUTH] = flit_out [x][y-1][NORTH];
        assign valid_in[x][y][SOUTH] = valid_out[x][y-1][NORTH];
        assign ready_in[x][y][SOUTH] = ready_out[x][y-1][NORTH];
      end else begin : gen_south_edge
        assign flit_in [x][y][SOUTH] = '0;
        assign valid_in[x][y][SOUTH] = 1'b0;
        assign ready_in[x][y][SOUTH] = 1'b0;
      end

      if (y < NumY - 1) begin : gen_north_link
        assign flit_in [x][y][NORTH] = flit_out [x][y+1][SOUTH];
        assign valid_in[x][y][NORTH] = valid_out[x][y+1][SOUTH];
        assign ready_in[x][y][NORTH] = ready_out[x][y+1][SOUTH];
      end else begin : gen_north_edge
        assign flit_in [x][y][NORTH] = '0;
        assign valid_in[x][y][NORTH] = 1'b0;
        assign ready_in[x][y][NORTH] = 1'b0;
      end

      // Bank never stalls
      assign ready_in[x][y][LOCAL] = 1'b1;

      dma_spill_register i_dma_spill_register (
        .clk_i   (clk_i                    ),
        .arst_n_i(arst_n_i                 ),
        .data_i  (dma_req_i[G]             ),
        .valid_i (dma_req_valid_i[G]       ),
        .ready_o (dma_req_ready_o[G]       ),
        .data_o  (flit_in[x][y][LOCAL]     ),
        .valid_o (valid_in[x][y][LOCAL]    ),
        .ready_i (ready_out[x][y][LOCAL]   )
      );

      mesh_router #(
        .NumX  (NumX),
        .NumY  (NumY),
        .GroupX(x   ),
        .GroupY(y   )
      ) i_mesh_router (
        .clk_i   (clk_i           ),
        .arst_n_i(arst_n_i        ),
        .flit_i  (flit_in[x][y]   ),
        .valid_i (valid_in[x][y]  ),
        .ready_o (ready_out[x][y] ),
        .flit_o  (flit_out[x][y]  ),
        .valid_o (valid_out[x][y] ),
        .ready_i (ready_in[x][y]  )
      );

      group_bank #(
        .GroupX(x),
        .GroupY(y)
      ) i_group_bank (
        .clk_i      (clk_i                  ),
        .arst_n_i   (arst_n_i               ),
        .req_i      (flit_out[x][y][LOCAL]  ),
        .req_valid_i(valid_out[x][y][LOCAL] ),
        .meta_o     (dma_meta[G]            )
      );
    end : gen_groups_y
  end : gen_groups_x

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dma_meta_q <= '0;
    end else begin
      dma_meta_q <= dma_meta;
    end
  end

  assign dma_meta_o = dma_meta_q;

  if (NumX > 2 ** MaxCoord || NumY > 2 ** MaxCoord)
    $fatal(1, "[mesh] Mesh size does not fit the coordinate width.");

endmodule : mempool_mesh_cluster

// File: hw/mesh_pkg.sv
// ****************************************
// Mesh cluster package with sizes, router
// directions, DMA opcodes and DMA types
// ****************************************

package mesh_pkg;

  // Mesh dimensions
  localparam int unsigned DefaultNumX = 2;
  localparam int unsigned DefaultNumY = 2;
  localparam int unsigned MaxCoord    = 2;

  // One local port plus four neighbours
  localparam int unsigned NumPorts = 5;

  // Group bank geometry
  localparam int unsigned BankWords = 16;
  localparam int unsigned DataWidth = 32;

  typedef logic [MaxCoord-1:0]          coord_t;
  typedef logic [$clog2(BankWords)-1:0] bank_addr_t;
  typedef logic [DataWidth-1:0]         data_t;

  // Router port index, also used to pick the output of a flit
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    SOUTH = 3'd3,
    WEST  = 3'd4
  } mesh_dir_e;

  typedef enum logic [1:0] {
    DMA_WRITE = 2'd0,
    DMA_ADD   = 2'd1,
    DMA_CLEAR = 2'd2
  } dma_op_e;

  // DMA request as it travels through the mesh
  typedef struct packed {
    coord_t     dst_x;
    coord_t     dst_y;
    dma_op_e    op;
    bank_addr_t addr;
    data_t      data;
  } dma_req_t;

  // Per group DMA status
  typedef struct packed {
    logic [7:0] count;
    data_t      last;
  } dma_meta_t;

endpackage : mesh_pkg

// File: hw/mesh_router.sv
// ****************************************
// Five port XY mesh router with one output
// register per port and round-robin arbiters
// ****************************************

module mesh_router
  import mesh_pkg::*;
#(
  parameter int unsigned NumX   = DefaultNumX,
  parameter int unsigned NumY   = DefaultNumY,
  parameter int unsigned GroupX = 0,
  parameter int unsigned GroupY = 0
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  dma_req_t [NumPorts-1:0] flit_i,
  input  logic     [NumPorts-1:0] valid_i,
  output logic     [NumPorts-1:0] ready_o,
  output dma_req_t [NumPorts-1:0] flit_o,
  output logic     [NumPorts-1:0] valid_o,
  input  logic     [NumPorts-1:0] ready_i
);

  // Outputs that point off the mesh, ordered WEST down to LOCAL
  localparam logic [NumPorts-1:0] EdgeMask = {
    GroupX == 0, GroupY == 0, GroupX == NumX - 1, GroupY == NumY - 1, 1'b0
  };

  mesh_dir_e                         route [NumPorts];
  logic      [NumPorts-1:0][NumPorts-1:0] grant;
  logic      [NumPorts-1:0][2:0]     win_idx;
  dma_req_t  [NumPorts-1:0]          win_flit;
  logic      [NumPorts-1:0]          out_free;
  logic      [NumPorts-1:0]          out_fill;
  logic      [NumPorts-1:0][2:0]     rr_q;
  logic      [NumPorts-1:0]          out_valid_q;
  dma_req_t  [NumPorts-1:0]          out_q;

  // X first, then Y, then deliver
  function automatic mesh_dir_e xy_route(dma_req_t req);
    if (req.dst_x > coord_t'(GroupX)) begin
      return EAST;
    end else if (req.dst_x < coord_t'(GroupX)) begin
      return WEST;
    end else if (req.dst_y > coord_t'(GroupY)) begin
      return NORTH;
    end else if (req.dst_y < coord_t'(GroupY)) begin
      return SOUTH;
    end
    return LOCAL;
  endfunction

  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      route[i] = xy_route(flit_i[i]);
    end
  end

  // Search starts one past the last winner of each output
  always_comb begin
    int unsigned idx;
    logic        found;
    grant    = '0;
    win_idx  = '0;
    win_flit = '0;
    for (int o = 0; o < NumPorts; o++) begin
      found = 1'b0;
      for (int unsigned k = 1; k <= NumPorts; k++) begin
        idx = (rr_q[o] + k) % NumPorts;
        if (!found && valid_i[idx] && route[idx] == mesh_dir_e'(o)) begin
          grant[o][idx] = 1'b1;
          win_idx[o]    = 3'(idx);
          win_flit[o]   = flit_i[idx];
          found         = 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      out_free[o] = ~out_valid_q[o] | ready_i[o];
      out_fill[o] = (|grant[o]) & out_free[o];
    end
    for (int i = 0; i < NumPorts; i++) begin
      ready_o[i] = grant[route[i]][i] & out_free[route[i]];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= '0;
      rr_q        <= '0;
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        if (out_fill[o]) begin
          out_valid_q[o] <= 1'b1;
          rr_q[o]        <= win_idx[o];
        end else if (ready_i[o]) begin
          out_valid_q[o] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NumPorts; o++) begin
      if (out_fill[o]) begin
        out_q[o] <= win_flit[o];
      end
    end
  end

  assign flit_o  = out_q;
  assign valid_o = out_valid_q;

  // XY routing from any source never aims at a tied-off edge
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_q & EdgeMask) == '0);

endmodule : mesh_router

// File: sim.f
hw/mesh_pkg.sv
hw/dma_spill_register.sv
hw/mesh_router.sv
hw/group_bank.sv
hw/mempool_mesh_cluster.sv
test/tb_mempool_mesh_cluster.sv

// File: test/mesh_golden.txt
# R src dst_x dst_y op addr data   (src = x*NumY+y, addr and data in hex)
# P bp, then count (decimal) and last (hex) for groups 0..3, bp=1 expects back-pressure
P 0 0 00000000 0 00000000 0 00000000 0 00000000
R 0 0 0 WRITE 1 00000011
R 1 0 1 WRITE 2 00000022
R 2 1 0 WRITE 3 00000033
R 3 1 1 WRITE 4 00000044
P 0 1 00000011 1 00000022 1 00000033 1 00000044
R 0 1 1 WRITE 5 00000aaa
P 0 1 00000011 1 00000022 1 00000033 2 00000aaa
R 1 0 0 WRITE 6 00000bbb
R 3 1 0 WRITE 7 00000ccc
P 0 2 00000bbb 1 00000022 2 00000ccc 2 00000aaa
R 2 0 1 ADD 9 00000005
R 2 0 1 ADD 9 fffffffe
R 2 0 1 ADD 9 00000010
P 0 2 00000bbb 4 00000013 2 00000ccc 2 00000aaa
R 2 0 1 CLEAR 9 00000000
P 0 2 00000bbb 5 00000000 2 00000ccc 2 00000aaa
R 0 1 1 ADD c 00000001
R 1 1 1 ADD c 00000010
R 2 1 1 ADD c 00000100
R 3 1 1 ADD c 00001000
R 0 1 1 ADD c 00000002
R 1 1 1 ADD c 00000020
R 2 1 1 ADD c 00000200
R 3 1 1 ADD c 00002000
R 0 1 1 ADD c 00000003
R 1 1 1 ADD c 00000030
R 2 1 1 ADD c 00000300
R 3 1 1 ADD c 00003000
P 1 2 00000bbb 5 00000000 2 00000ccc 14 00006666

// File: test/tb_mempool_mesh_cluster.sv
// ****************************************
// Mesh cluster testbench that replays the
// golden DMA phases and checks group status
// ****************************************

module tb_mempool_mesh_cluster
  import mesh_pkg::*;
;

  localparam int NumX      = DefaultNumX;
  localparam int NumY      = DefaultNumY;
  localparam int NumGroups = NumX * NumY;
  localparam int Timeout   = 2000;

  logic                      clk_i;
  logic                      arst_n_i;
  dma_req_t  [NumGroups-1:0] dma_req_i;
  logic      [NumGroups-1:0] dma_req_valid_i;
  logic      [NumGroups-1:0] dma_req_ready_o;
  dma_meta_t [NumGroups-1:0] dma_meta_o;

  dma_req_t  pend [NumGroups][$];
  data_t     model_mem [NumGroups][BankWords];
  dma_meta_t model_meta [NumGroups];
  dma_meta_t expected [NumGroups];
  int        seed;
  int        errors;
  int        timeouts;
  int        bp_cycles;
  bit        bp_watch;

  mempool_mesh_cluster #(
    .NumX(NumX),
    .NumY(NumY)
  ) i_mempool_mesh_cluster (
    .clk_i          (clk_i          ),
    .arst_n_i       (arst_n_i       ),
    .dma_req_i      (dma_req_i      ),
    .dma_req_valid_i(dma_req_valid_i),
    .dma_req_ready_o(dma_req_ready_o),
    .dma_meta_o     (dma_meta_o     )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Cycles where some DMA input is stalled
  always @(negedge clk_i) begin
    if (bp_watch && dma_req_ready_o != '1) begin
      bp_cycles++;
    end
  end

  task automatic check_meta(input string name, input dma_meta_t actual,
                            input dma_meta_t exp_meta);
    if (actual !== exp_meta) begin
      $display("CHECK FAILED t=%0t %s expected count=%0d last=%h actual count=%0d last=%h",
               $time, name, exp_meta.count, exp_meta.last, actual.count, actual.last);
      errors++;
    end
  endtask

  task automatic check_ready(input string name, input logic actual, input logic exp_ready);
    if (actual !== exp_ready) begin
      $display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp_ready, actual);
      errors++;
    end
  endtask

  function automatic dma_op_e op_from_name(input string name);
    if (name == "WRITE") begin
      return DMA_WRITE;
    end
    if (name == "ADD") begin
      return DMA_ADD;
    end
    if (name == "CLEAR") begin
      return DMA_CLEAR;
    end
    $display("ERROR: unknown opcode %s in the golden file", name);
    errors++;
    return DMA_WRITE;
  endfunction

  // Reference bank model applied in file order
  function automatic void apply_model(input dma_req_t req);
    int    g;
    data_t word;
    g = int'(req.dst_x) * NumY + int'(req.dst_y);
    case (req.op)
      DMA_WRITE: word = req.data;
      DMA_ADD:   word = model_mem[g][req.addr] + req.data;
      default:   word = '0;
    endcase
    model_mem[g][req.addr] = word;
    model_meta[g].count    = model_meta[g].count + 8'd1;
    model_meta[g].last     = word;
  endfunction

  // Starts on a falling edge and returns on the falling edge after the transfer
  task automatic send_req(input int src, input dma_req_t req);
    int waited;
    waited                 = 0;
    dma_req_i[src]         = req;
    dma_req_valid_i[src]   = 1'b1;
    while (dma_req_ready_o[src] !== 1'b1) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        $display("ERROR: DMA input of group %0d stalled at t=%0t", src, $time);
        timeouts++;
        break;
      end
    end
    @(negedge clk_i);
    dma_req_valid_i[src] = 1'b0;
  endtask

  task automatic drain_queue(input int src, input bit gaps);
    dma_req_t req;
    while (pend[src].size() > 0 && timeouts == 0) begin
      req = pend[src].pop_front();
      if (gaps && ($random(seed) & 3) == 0) begin
        @(negedge clk_i);
      end
      send_req(src, req);
    end
  endtask

  task automatic run_phase(input int phase, input int bp);
    int waited;
    bp_cycles = 0;
    bp_watch  = 1'b1;
    for (int g = 0; g < NumGroups; g++) begin
      fork
        automatic int src = g;
        drain_queue(src, bp == 0);
      join_none
    end
    wait fork;
    for (int g = 0; g < NumGroups && timeouts == 0; g++) begin
      waited = 0;
      while (dma_meta_o[g].count !== expected[g].count) begin
        @(negedge clk_i);
        waited++;
        if (waited > Timeout) begin
          $display("ERROR: group %0d stalled in phase %0d before count %0d",
                   g, phase, expected[g].count);
          timeouts++;
          break;
        end
      end
    end
    // Stalls keep building while the mesh drains
    bp_watch = 1'b0;
    if (bp != 0 && bp_cycles == 0) begin
      $display("ERROR: phase %0d saw no back-pressure on any DMA input", phase);
      errors++;
    end
    for (int g = 0; g < NumGroups; g++) begin
      if (model_meta[g] !== expected[g]) begin
        $display("ERROR: golden status of group %0d in phase %0d disagrees with the model",
                 g, phase);
        errors++;
      end
      check_meta($sformatf("dma_meta_o[%0d]", g), dma_meta_o[g], expected[g]);
      check_ready($sformatf("dma_req_ready_o[%0d]", g), dma_req_ready_o[g], 1'b1);
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int          src;
    int          dx;
    int          dy;
    int          addr;
    int          bp;
    int          cnt;
    int          phase;
    string       tag;
    string       opname;
    string       line;
    logic [31:0] data;
    logic [31:0] last;
    dma_req_t    req;
    seed            = 32'hcd74;
    errors          = 0;
    timeouts        = 0;
    bp_watch        = 1'b0;
    bp_cycles       = 0;
    phase           = 0;
    arst_n_i        = 1'b0;
    dma_req_i       = '0;
    dma_req_valid_i = '0;
    for (int g = 0; g < NumGroups; g++) begin
      model_meta[g] = '0;
      for (int w = 0; w < BankWords; w++) begin
        model_mem[g][w] = '0;
      end
    end
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    fd = $fopen("test/mesh_golden.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open test/mesh_golden.txt");
      errors++;
    end
    while (fd != 0 && timeouts == 0 && !$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        break;
      end
      if (tag == "R") begin
        code = $fscanf(fd, "%d %d %d %s %h %h", src, dx, dy, opname, addr, data);
        if (code != 6 || src < 0 || src >= NumGroups) begin
          $display("ERROR: malformed request record in the golden file");
          errors++;
          break;
        end
        req.dst_x = coord_t'(dx);
        req.dst_y = coord_t'(dy);
        req.op    = op_from_name(opname);
        req.addr  = bank_addr_t'(addr);
        req.data  = data;
        pend[src].push_back(req);
        apply_model(req);
      end else if (tag == "P") begin
        code = $fscanf(fd, "%d", bp);
        for (int g = 0; g < NumGroups; g++) begin
          code += $fscanf(fd, "%d %h", cnt, last);
          expected[g].count = cnt[7:0];
          expected[g].last  = last;
        end
        if (code != 1 + 2 * NumGroups) begin
          $display("ERROR: malformed phase record in the golden file");
          errors++;
          break;
        end
        run_phase(phase, bp);
        phase++;
      end else begin
        code = $fgets(line, fd);
      end
    end
    // A late duplicate would still move a count here
    if (timeouts == 0) begin
      repeat (40) @(negedge clk_i);
      for (int g = 0; g < NumGroups; g++) begin
        check_meta($sformatf("dma_meta_o[%0d]", g), dma_meta_o[g], expected[g]);
      end
    end
    $display("Phases run: %0d, check errors: %0d, timeouts: %0d", phase, errors, timeouts);
    if (errors == 0 && timeouts == 0 && phase > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_mempool_mesh_cluster
